/* Bender.yml */
package:
  name: link_top

sources:
  - files:
      - design/phy_pkg.sv
      - design/chan_pkg.sv
      - design/link_sync.sv
      - design/chan_pack.sv
      - design/lane_stripe.sv
      - design/link_top.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/tb_link_top.sv

/* compile.f */
design/phy_pkg.sv
design/chan_pkg.sv
design/link_sync.sv
design/chan_pack.sv
design/lane_stripe.sv
design/link_top.sv
sim/tb_clock.sv
sim/tb_link_top.sv

/* design/chan_pack.sv */
/*
 * User interface stage.
 * Registers the downstream channel into the transmit word and the
 * received word out to the upstream channel, one cycle each way.
 */

`default_nettype none

module chan_pack
  import chan_pkg::*;
(
  input  logic       clk_wr,
  input  logic       reset,
  input  chan_word_t dstrm,
  input  chan_word_t rx_word,
  output chan_word_t tx_word,
  output chan_word_t ustrm
);

  chan_word_t ustrm_next;

  ////////////////////////////////////////////////////////////
  // Downstream
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_word <= '0;
    end else begin
      tx_word <= dstrm;
    end
  end

  ////////////////////////////////////////////////////////////
  // Upstream
  ////////////////////////////////////////////////////////////

  // Idle words come out with data and crc cleared
  always_comb begin
    ustrm_next = rx_word;
    if (!rx_word.valid) begin
      ustrm_next.data = '0;
      ustrm_next.crc  = '0;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ustrm <= '0;
    end else begin
      ustrm <= ustrm_next;
    end
  end

endmodule

`default_nettype wire

/* design/chan_pkg.sv */
/*
 * User channel definitions for the logic link.
 * Field widths and the packed channel word shared by the
 * downstream and upstream directions.
 */

`default_nettype none

package chan_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned state_width  = 4;
  localparam int unsigned protid_width = 2;
  localparam int unsigned data_width   = 128;
  localparam int unsigned crc_width    = 16;

  // Field order runs from the most significant end
  typedef struct packed {
    logic [state_width-1:0]  state;
    logic [protid_width-1:0] protid;
    logic [data_width-1:0]   data;
    logic                    dvalid;
    logic [crc_width-1:0]    crc;
    logic                    crc_valid;
    // Word carries real data when set
    logic                    valid;
  } chan_word_t;

  // 153 bits wide and padded to the lane payload when striped
  localparam int unsigned chan_word_width =
    state_width + protid_width + data_width + 1 + crc_width + 1 + 1;

endpackage

`default_nettype wire

/* design/lane_stripe.sv */
/*
 * Lane striping stage.
 * Pads the channel word and cuts it into 39-bit lane slices with the
 * strobe and marker in bit 39, and joins received lanes back into a
 * channel word. One register stage in each direction.
 */

`default_nettype none

module lane_stripe
  import phy_pkg::*;
  import chan_pkg::*;
(
  input  logic       clk_wr,
  input  logic       reset,
  input  chan_word_t tx_word,
  input  logic       tx_online_delay,
  input  logic       tx_auto_stb,
  input  logic       tx_auto_mrk,
  input  phy_lanes_t rx_phy,
  input  logic       rx_online_delay,
  output phy_lanes_t tx_phy,
  output chan_word_t rx_word
);

  logic [phy_payload_width-1:0] tx_padded;
  logic [phy_payload_width-1:0] rx_joined;
  phy_lanes_t                   tx_lanes;

  ////////////////////////////////////////////////////////////
  // Transmit striping
  ////////////////////////////////////////////////////////////

  always_comb begin
    tx_padded                        = '0;
    tx_padded[chan_word_width-1:0]   = tx_word;
    for (int i = 0; i < lane_count; i++) begin
      tx_lanes[i][lane_payload-1:0] = tx_padded[i*lane_payload +: lane_payload];
      // Strobe rides on lane 0, marker on all others
      tx_lanes[i][lane_width-1]     = (i == 0) ? tx_auto_stb : tx_auto_mrk;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_lanes;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive de-striping
  ////////////////////////////////////////////////////////////

  // User bits are dropped here
  always_comb begin
    for (int i = 0; i < lane_count; i++) begin
      rx_joined[i*lane_payload +: lane_payload] = rx_phy[i][lane_payload-1:0];
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online_delay) begin
      rx_word <= '0;
    end else begin
      rx_word <= chan_word_t'(rx_joined[chan_word_width-1:0]);
    end
  end

endmodule

`default_nettype wire

/* design/link_sync.sv */
/*
 * Link bring-up.
 * Delays the transmit and receive online requests by programmable
 * counts, gates the strobe and marker user bits until transmit is
 * online, and reports both online flags in a debug word.
 */

`default_nettype none

module link_sync
  import phy_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   reset,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [delay_width-1:0] delay_x_value,
  input  logic [delay_width-1:0] delay_y_value,
  input  logic                   tx_stb_userbit,
  input  logic                   tx_mrk_userbit,
  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output logic                   tx_auto_stb,
  output logic                   tx_auto_mrk,
  output logic [debug_width-1:0] debug_status
);

  // Index 0 is the transmit direction, index 1 the receive one
  logic                   online_req [2];
  logic [delay_width-1:0] delay_sel  [2];
  sync_state_e            state_q    [2];
  logic [delay_width-1:0] count_q    [2];

  assign online_req[0] = tx_online;
  assign online_req[1] = rx_online;
  // Transmit uses the y delay, receive the x delay
  assign delay_sel[0]  = delay_y_value;
  assign delay_sel[1]  = delay_x_value;

  ////////////////////////////////////////////////////////////
  // Online delay FSMs
  ////////////////////////////////////////////////////////////

  // Dropping the request returns to offline at once.
  // Online is reached delay + 1 edges after leaving offline
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (reset || !online_req[i]) begin
        state_q[i] <= sync_offline;
        count_q[i] <= '0;
      end else if (state_q[i] == sync_offline) begin
        state_q[i] <= sync_counting;
        count_q[i] <= '0;
      end else if (state_q[i] == sync_counting) begin
        if (count_q[i] == delay_sel[i]) begin
          state_q[i] <= sync_online;
        end else begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  assign tx_online_delay = (state_q[0] == sync_online);
  assign rx_online_delay = (state_q[1] == sync_online);

  ////////////////////////////////////////////////////////////
  // User bits
  ////////////////////////////////////////////////////////////

  // Held at zero until the transmit side is up
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      tx_auto_stb <= 1'b0;
      tx_auto_mrk <= 1'b0;
    end else begin
      tx_auto_stb <= tx_stb_userbit;
      tx_auto_mrk <= tx_mrk_userbit;
    end
  end

  // Debug word carries the online flags only
  always_comb begin
    debug_status               = '0;
    debug_status[debug_tx_bit] = tx_online_delay;
    debug_status[debug_rx_bit] = rx_online_delay;
  end

endmodule

`default_nettype wire

/* design/link_top.sv */
/*
 * Logic link top level.
 * One user channel sent across four PHY lanes, with bring-up
 * timing, a user interface stage and a lane striping stage.
 */

`default_nettype none

module link_top
  import phy_pkg::*;
  import chan_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   reset,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [delay_width-1:0] delay_x_value,
  input  logic [delay_width-1:0] delay_y_value,
  input  logic                   tx_stb_userbit,
  input  logic                   tx_mrk_userbit,
  input  chan_word_t             dstrm,
  output chan_word_t             ustrm,
  output phy_lanes_t             tx_phy,
  input  phy_lanes_t             rx_phy,
  output logic [debug_width-1:0] debug_status
);

  chan_word_t tx_word;
  chan_word_t rx_word;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_auto_stb;
  logic       tx_auto_mrk;

  ////////////////////////////////////////////////////////////
  // Bring-up
  ////////////////////////////////////////////////////////////

  link_sync i_link_sync (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_stb     (tx_auto_stb),
    .tx_auto_mrk     (tx_auto_mrk),
    .debug_status    (debug_status)
  );

  ////////////////////////////////////////////////////////////
  // User interface and PHY interface
  ////////////////////////////////////////////////////////////

  chan_pack i_chan_pack (
    .clk_wr  (clk_wr),
    .reset   (reset),
    .dstrm   (dstrm),
    .rx_word (rx_word),
    .tx_word (tx_word),
    .ustrm   (ustrm)
  );

  lane_stripe i_lane_stripe (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_word         (tx_word),
    .tx_online_delay (tx_online_delay),
    .tx_auto_stb     (tx_auto_stb),
    .tx_auto_mrk     (tx_auto_mrk),
    .rx_phy          (rx_phy),
    .rx_online_delay (rx_online_delay),
    .tx_phy          (tx_phy),
    .rx_word         (rx_word)
  );

endmodule

`default_nettype wire

/* design/phy_pkg.sv */
/*
 * PHY side definitions for the logic link.
 * Lane geometry, the lane bundle carried between link partners,
 * the bring-up state encoding and the debug status layout.
 */

`default_nettype none

package phy_pkg;

  ////////////////////////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned lane_count   = 4;
  localparam int unsigned lane_width   = 40;
  // Bit 39 of every lane is reserved for the user bit
  localparam int unsigned lane_payload = 39;
  // Payload bits across all lanes without user bits
  localparam int unsigned phy_payload_width = lane_count * lane_payload;

  // Lane 0 occupies the low 40 bits
  typedef logic [lane_count-1:0][lane_width-1:0] phy_lanes_t;

  ////////////////////////////////////////////////////////////
  // Bring-up
  ////////////////////////////////////////////////////////////

  localparam int unsigned delay_width = 16;

  typedef enum logic [1:0] {
    sync_offline,
    sync_counting,
    sync_online
  } sync_state_e;

  // Debug status word layout
  localparam int unsigned debug_width  = 32;
  localparam int unsigned debug_tx_bit = 19;
  localparam int unsigned debug_rx_bit = 18;

endpackage

`default_nettype wire

/* sim/link_input.txt */
# test delay_x delay_y stb mrk words
# delays in clock cycles, stb and mrk are single bits
1 0 0 1 0 8
2 3 5 0 1 12
3 7 2 1 1 16
4 12 9 0 0 10
5 1 20 1 0 24
6 4 4 0 1 6

/* sim/tb_clock.sv */
/*
 * Testbench clock source.
 * Free running clock with a 40 unit period.
 */

`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int half_period = 20;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

`default_nettype wire

/* sim/tb_link_top.sv */
/*
 * Loopback testbench for the logic link.
 * Reads tests from sim/link_input.txt, brings the link up, streams
 * random channel words with tx_phy looped to rx_phy and checks
 * bring-up timing, user bits, striping, loopback and going offline.
 */

`default_nettype none

module tb_link_top
  import phy_pkg::*;
  import chan_pkg::*;
();

  localparam int reset_cycles = 16;
  localparam int max_tests    = 32;

  logic                   clk_wr;
  logic                   reset;
  logic                   tx_online;
  logic                   rx_online;
  logic [delay_width-1:0] delay_x_value;
  logic [delay_width-1:0] delay_y_value;
  logic                   tx_stb_userbit;
  logic                   tx_mrk_userbit;
  chan_word_t             dstrm;
  chan_word_t             ustrm;
  phy_lanes_t             phy_loop;
  logic [debug_width-1:0] debug_status;

  // Test table from the data file
  int test_id [max_tests];
  int dx      [max_tests];
  int dy      [max_tests];
  int stb     [max_tests];
  int mrk     [max_tests];
  int words   [max_tests];

  int          num_tests   = 0;
  int          errors      = 0;
  int          test_errors = 0;
  int          checks      = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;
  logic [31:0] seed        = 32'h295c;

  tb_clock i_clock (
    .clk (clk_wr)
  );

  link_top i_dut (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_mrk_userbit (tx_mrk_userbit),
    .dstrm          (dstrm),
    .ustrm          (ustrm),
    .tx_phy         (phy_loop),
    .rx_phy         (phy_loop),
    .debug_status   (debug_status)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // Five draws per word, so valid alternates
  function automatic chan_word_t random_word();
    chan_word_t  w;
    logic [31:0] r;
    r           = lcg_step();
    w.state     = r[31:28];
    w.protid    = r[27:26];
    w.dvalid    = r[25];
    w.crc_valid = r[24];
    w.crc       = r[23:8];
    w.valid     = r[0];
    for (int i = 0; i < 4; i++) begin
      w.data[i*32 +: 32] = lcg_step();
    end
    return w;
  endfunction

  function automatic chan_word_t idle_cleared(input chan_word_t w);
    chan_word_t e;
    e = w;
    if (!w.valid) begin
      e.data = '0;
      e.crc  = '0;
    end
    return e;
  endfunction

  // Field layout plus three pad bits on top
  function automatic logic [155:0] padded_word(input chan_word_t w);
    return {3'b000, w.state, w.protid, w.data, w.dvalid, w.crc, w.crc_valid, w.valid};
  endfunction

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input int id);
    $display("Test %0d: %s, %0d errors", id, (test_errors == 0) ? "pass" : "fail",
             test_errors);
  endtask

  ////////////////////////////////////////////////////////////
  // One test with bring-up, streaming and going offline
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    chan_word_t       sent [$];
    chan_word_t       w;
    logic [155:0]     exp_payload;
    logic [3:0]       exp_user;
    logic [31:0]      online_word;
    int               n;
    int               tx_rise;
    int               rx_rise;
    test_errors = 0;
    online_word = (32'd1 << debug_tx_bit) | (32'd1 << debug_rx_bit);
    exp_user    = {mrk[t][0], mrk[t][0], mrk[t][0], stb[t][0]};
    @(posedge clk_wr);
    delay_x_value  <= 16'(dx[t]);
    delay_y_value  <= 16'(dy[t]);
    tx_stb_userbit <= stb[t][0];
    tx_mrk_userbit <= mrk[t][0];
    tx_online      <= 1'b1;
    rx_online      <= 1'b1;
    // n is 0 at the first edge that samples the online inputs
    n       = -1;
    tx_rise = -1;
    rx_rise = -1;
    while (tx_rise < 0 || rx_rise < 0) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      n++;
      if (debug_status[debug_tx_bit] && tx_rise < 0) tx_rise = n;
      if (debug_status[debug_rx_bit] && rx_rise < 0) rx_rise = n;
      if (tx_rise < 0 || tx_rise == n) check_value("tx_phy", phy_loop, '0);
    end
    check_value("debug_status[19] rise edge", tx_rise, dy[t] + 1);
    check_value("debug_status[18] rise edge", rx_rise, dx[t] + 1);
    check_value("debug_status", debug_status, online_word);
    repeat (2) @(posedge clk_wr);

    for (int c = 0; c < words[t] + 4; c++) begin
      @(posedge clk_wr);
      if (c < words[t]) begin
        w = random_word();
        sent.push_back(w);
        dstrm <= w;
      end else begin
        dstrm <= '0;
      end
      @(negedge clk_wr);
      check_value("tx_phy user bits",
                  {phy_loop[3][39], phy_loop[2][39], phy_loop[1][39], phy_loop[0][39]},
                  exp_user);
      if (c >= 2 && c - 2 < words[t]) begin
        exp_payload = padded_word(sent[c-2]);
        for (int i = 0; i < lane_count; i++) begin
          check_value($sformatf("tx_phy lane %0d payload", i),
                      phy_loop[i][lane_payload-1:0],
                      exp_payload[i*lane_payload +: lane_payload]);
        end
      end
      if (c >= 4) check_value("ustrm", ustrm, idle_cleared(sent[c-4]));
    end

    // Going offline
    @(posedge clk_wr);
    tx_online <= 1'b0;
    rx_online <= 1'b0;
    @(negedge clk_wr);
    check_value("debug_status", debug_status, online_word);
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_value("debug_status", debug_status, '0);
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_value("tx_phy", phy_loop, '0);
    report_test(test_id[t]);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    string line;
    int    limit;
    reset          <= 1'b1;
    tx_online      <= 1'b0;
    rx_online      <= 1'b0;
    delay_x_value  <= '0;
    delay_y_value  <= '0;
    tx_stb_userbit <= 1'b0;
    tx_mrk_userbit <= 1'b0;
    dstrm          <= '0;

    fd = $fopen("sim/link_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file sim/link_input.txt");
      errors++;
    end else begin
      while (!$feof(fd) && num_tests < max_tests) begin
        if ($fgets(line, fd) > 0) begin
          if ($sscanf(line, "%d %d %d %d %d %d", test_id[num_tests], dx[num_tests],
                      dy[num_tests], stb[num_tests], mrk[num_tests],
                      words[num_tests]) == 6) num_tests++;
        end
      end
      $fclose(fd);
      if (num_tests == 0) begin
        $display("The test file holds no tests");
        errors++;
      end
    end
    limit = reset_cycles + 2;
    for (int t = 0; t < num_tests; t++) begin
      limit += dx[t] + dy[t] + words[t] + 30;
    end
    cycle_limit = limit;

    // Registers read zero during and after reset
    for (int k = 1; k <= reset_cycles; k++) begin
      @(posedge clk_wr);
      if (k == reset_cycles) reset <= 1'b0;
      @(negedge clk_wr);
      check_value("tx_phy", phy_loop, '0);
      check_value("ustrm", ustrm, '0);
      check_value("debug_status", debug_status, '0);
    end
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_value("tx_phy", phy_loop, '0);
    check_value("ustrm", ustrm, '0);
    check_value("debug_status", debug_status, '0);
    report_test(0);

    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end

    $display("Tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk_wr) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

`default_nettype wire
